// File: hdl/vm16_pkg.sv
/* ISA encodings, address map, widths and bus structs shared by the vm16 core and SoC
   compiled first; other files refer to it by scoped name */
package vm16_pkg;

    localparam int word_w      = 16;
    localparam int reg_sel_w   = 3;
    localparam int num_regs    = 8;
    localparam int instr_depth = 64;
    localparam int tim0_depth  = 64;
    localparam int instr_aw    = $clog2(instr_depth);
    localparam int tim0_aw     = $clog2(tim0_depth);

    // address map
    localparam logic [word_w-1:0] addr_tim0_start = 16'h0000;
    localparam logic [word_w-1:0] addr_tim0_end   = 16'h003F;
    localparam logic [word_w-1:0] addr_gpio       = 16'h00C0;

    // opcode in instr[15:11]
    typedef enum logic [4:0] {
        NOP     = 5'h00,
        LW      = 5'h01,
        SW      = 5'h02,
        BIT     = 5'h03,
        MOV     = 5'h04,
        MOVI    = 5'h05,
        ARITH_U = 5'h07,
        ARITH_S = 5'h08
    } op_t;

    // sub-function in simm5, values overlap between opcodes
    typedef logic [4:0] sub_t;
    localparam sub_t BIT_OR     = 5'h00;
    localparam sub_t BIT_XOR    = 5'h01;
    localparam sub_t BIT_AND    = 5'h02;
    localparam sub_t BIT_NOT    = 5'h03;
    localparam sub_t BIT_LSHFT  = 5'h04;
    localparam sub_t BIT_RSHFT  = 5'h05;
    localparam sub_t ARITH_UADD = 5'h1F;
    localparam sub_t ARITH_USUB = 5'h10;
    localparam sub_t ARITH_SADD = 5'h1F;
    localparam sub_t ARITH_SSUB = 5'h10;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_LW, ALU_SW, ALU_MOV, ALU_MOVI,
        ALU_OR, ALU_XOR, ALU_AND, ALU_NOT, ALU_LSHFT, ALU_RSHFT,
        ALU_UADD, ALU_USUB, ALU_SADD, ALU_SSUB, ALU_BAD
    } alu_op_t;

    typedef struct packed {
        logic [reg_sel_w-1:0] rd;
        logic [reg_sel_w-1:0] ra;
        logic [7:0]           imm8;
        logic [4:0]           simm5;
        alu_op_t              alu_op;
        logic                 has_imm8;
        logic                 has_we;
        logic                 has_mem;
        logic                 has_mem_we;
    } dec_t;

    typedef struct packed {
        logic [word_w-1:0] addr;
        logic [word_w-1:0] wdata;
        logic              we;
    } mem_req_t;

    typedef struct packed {
        logic [word_w-1:0] paddr;
        logic              pwrite;
        logic              psel;
        logic              penable;
        logic [word_w-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [word_w-1:0] prdata;
        logic              pready;
    } apb_rsp_t;

    typedef enum logic [2:0] {IF, R1, R2, ME, WB} core_state_t;

endpackage

// File: hdl/vm16_bram.sv
/* synchronous single-port block RAM, one word per address
   serves as instruction memory and as the TIM0 scratch RAM */
`timescale 1ns/1ps

module vm16_bram #(
    parameter int depth = 64
) (
    input  logic                          clk,
    input  logic [$clog2(depth)-1:0]      addr,
    input  logic [vm16_pkg::word_w-1:0]   wdata,
    input  logic                          we,
    output logic [vm16_pkg::word_w-1:0]   rdata
);

    logic [vm16_pkg::word_w-1:0] mem [depth];

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // write has priority, read port holds during a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: hdl/vm16_decoder.sv
/* combinational instruction decoder
   splits the word into fields and picks the ALU op and control flags */
`timescale 1ns/1ps

module vm16_decoder (
    input  logic [vm16_pkg::word_w-1:0] instr,
    output vm16_pkg::dec_t              dec
);

    always_comb begin
        dec        = '0;
        dec.rd     = instr[10:8];
        dec.ra     = instr[7:5];
        dec.imm8   = instr[7:0];
        dec.simm5  = instr[4:0];
        dec.alu_op = vm16_pkg::ALU_NOP;

        case (instr[15:11])
            vm16_pkg::LW: begin
                dec.alu_op  = vm16_pkg::ALU_LW;
                dec.has_we  = 1'b1;
                dec.has_mem = 1'b1;
            end
            vm16_pkg::SW: begin
                dec.alu_op     = vm16_pkg::ALU_SW;
                dec.has_mem    = 1'b1;
                dec.has_mem_we = 1'b1;
            end
            vm16_pkg::MOV: begin
                dec.alu_op = vm16_pkg::ALU_MOV;
                dec.has_we = 1'b1;
            end
            vm16_pkg::MOVI: begin
                dec.alu_op   = vm16_pkg::ALU_MOVI;
                dec.has_we   = 1'b1;
                dec.has_imm8 = 1'b1;
            end
            vm16_pkg::BIT: begin
                dec.has_we = 1'b1;
                case (instr[4:0])
                    vm16_pkg::BIT_OR:    dec.alu_op = vm16_pkg::ALU_OR;
                    vm16_pkg::BIT_XOR:   dec.alu_op = vm16_pkg::ALU_XOR;
                    vm16_pkg::BIT_AND:   dec.alu_op = vm16_pkg::ALU_AND;
                    vm16_pkg::BIT_NOT:   dec.alu_op = vm16_pkg::ALU_NOT;
                    vm16_pkg::BIT_LSHFT: dec.alu_op = vm16_pkg::ALU_LSHFT;
                    vm16_pkg::BIT_RSHFT: dec.alu_op = vm16_pkg::ALU_RSHFT;
                    default:             dec.alu_op = vm16_pkg::ALU_BAD;
                endcase
            end
            vm16_pkg::ARITH_U: begin
                dec.has_we = 1'b1;
                case (instr[4:0])
                    vm16_pkg::ARITH_UADD: dec.alu_op = vm16_pkg::ALU_UADD;
                    vm16_pkg::ARITH_USUB: dec.alu_op = vm16_pkg::ALU_USUB;
                    default:              dec.alu_op = vm16_pkg::ALU_BAD;
                endcase
            end
            vm16_pkg::ARITH_S: begin
                dec.has_we = 1'b1;
                case (instr[4:0])
                    vm16_pkg::ARITH_SADD: dec.alu_op = vm16_pkg::ALU_SADD;
                    vm16_pkg::ARITH_SSUB: dec.alu_op = vm16_pkg::ALU_SSUB;
                    default:              dec.alu_op = vm16_pkg::ALU_BAD;
                endcase
            end
            // NOP and unknown opcodes do nothing
            default: dec.alu_op = vm16_pkg::ALU_NOP;
        endcase
    end

endmodule

// File: hdl/vm16_alu.sv
/* combinational ALU, a is the rd operand and b the ra or immediate operand */
`timescale 1ns/1ps

module vm16_alu (
    input  vm16_pkg::alu_op_t           op,
    input  logic [vm16_pkg::word_w-1:0] a,
    input  logic [vm16_pkg::word_w-1:0] b,
    output logic [vm16_pkg::word_w-1:0] c
);

    always_comb begin
        case (op)
            // moves and memory ops pass the second operand
            vm16_pkg::ALU_LW,
            vm16_pkg::ALU_SW,
            vm16_pkg::ALU_MOV,
            vm16_pkg::ALU_MOVI:  c = b;
            vm16_pkg::ALU_OR:    c = a | b;
            vm16_pkg::ALU_XOR:   c = a ^ b;
            vm16_pkg::ALU_AND:   c = a & b;
            vm16_pkg::ALU_NOT:   c = ~b;
            // shift amounts of 16 and up clear the result
            vm16_pkg::ALU_LSHFT: c = a << b;
            vm16_pkg::ALU_RSHFT: c = a >> b;
            vm16_pkg::ALU_UADD:  c = a + b;
            vm16_pkg::ALU_USUB:  c = a - b;
            vm16_pkg::ALU_SADD:  c = $signed(a) + $signed(b);
            vm16_pkg::ALU_SSUB:  c = $signed(a) - $signed(b);
            default:             c = '0;
        endcase
    end

endmodule

// File: hdl/vm16_regfile.sv
/* eight-entry register file, one combinational read port and one write port
   each register comes out of reset holding its own index */
`timescale 1ns/1ps

module vm16_regfile (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [vm16_pkg::reg_sel_w-1:0] rs,
    output logic [vm16_pkg::word_w-1:0]    rd,
    input  logic                           we,
    input  logic [vm16_pkg::reg_sel_w-1:0] ws,
    input  logic [vm16_pkg::word_w-1:0]    wd
);

    logic [vm16_pkg::word_w-1:0] regs [vm16_pkg::num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < vm16_pkg::num_regs; i++) begin
                regs[i] <= i[vm16_pkg::word_w-1:0];
            end
        end else if (we) begin
            regs[ws] <= wd;
        end
    end

    assign rd = regs[rs];

endmodule

// File: hdl/vm16_mmu.sv
/* memory unit behind the core, TIM0 for the low addresses, APB master otherwise
   takes a one-cycle req and answers with a one-cycle done and rdata */
`timescale 1ns/1ps

module vm16_mmu (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req,
    input  vm16_pkg::mem_req_t          mreq,
    output logic                        done,
    output logic [vm16_pkg::word_w-1:0] rdata,
    output vm16_pkg::apb_req_t          apb_m,
    input  vm16_pkg::apb_rsp_t          apb_s
);

    typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apb_state_t;

    apb_state_t                  state;
    logic                        in_tim0;
    logic [vm16_pkg::word_w-1:0] tim0_rdata;
    logic [vm16_pkg::word_w-1:0] apb_rdata;

    // address held stable by the core for the whole access
    assign in_tim0 = (mreq.addr >= vm16_pkg::addr_tim0_start)
                  && (mreq.addr <= vm16_pkg::addr_tim0_end);

    vm16_bram #(
        .depth (vm16_pkg::tim0_depth)
    ) tim0 (
        .clk   (clk),
        .addr  (mreq.addr[vm16_pkg::tim0_aw-1:0]),
        .wdata (mreq.wdata),
        .we    (req && in_tim0 && mreq.we),
        .rdata (tim0_rdata)
    );

    always_ff @(posedge clk) begin
        // transfer payload, latched at request time
        if (req) begin
            apb_m.paddr  <= mreq.addr;
            apb_m.pwrite <= mreq.we;
            apb_m.pwdata <= mreq.wdata;
        end
        if (state == APB_ACCESS && apb_s.pready) begin
            apb_rdata <= apb_s.prdata;
        end

        if (reset) begin
            state         <= APB_IDLE;
            apb_m.psel    <= 1'b0;
            apb_m.penable <= 1'b0;
            done          <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                APB_IDLE: begin
                    if (req && in_tim0) begin
                        done <= 1'b1;
                    end else if (req) begin
                        apb_m.psel <= 1'b1;
                        state      <= APB_SETUP;
                    end
                end
                APB_SETUP: begin
                    apb_m.penable <= 1'b1;
                    state         <= APB_ACCESS;
                end
                APB_ACCESS: begin
                    // slave finished, drop the bus next cycle
                    if (apb_s.pready) begin
                        apb_m.psel    <= 1'b0;
                        apb_m.penable <= 1'b0;
                        done          <= 1'b1;
                        state         <= APB_IDLE;
                    end
                end
                default: state <= APB_IDLE;
            endcase
        end
    end

    assign rdata = in_tim0 ? tim0_rdata : apb_rdata;

    // core keeps one request outstanding at a time
    a_one_outstanding: assert property (
        @(posedge clk) disable iff (reset) req |-> (state == APB_IDLE && !done)
    );

endmodule

// File: hdl/vm16_apb_fabric.sv
/* APB address decoder and read mux between the MMU master and its slaves
   GPIO sits at addr_gpio, every other address reads as zero */
`timescale 1ns/1ps

module vm16_apb_fabric (
    input  vm16_pkg::apb_req_t m_req,
    output vm16_pkg::apb_rsp_t m_rsp,
    output vm16_pkg::apb_req_t gpio_req,
    input  vm16_pkg::apb_rsp_t gpio_rsp
);

    logic gpio_hit;

    assign gpio_hit = (m_req.paddr == vm16_pkg::addr_gpio);

    always_comb begin
        gpio_req      = m_req;
        gpio_req.psel = m_req.psel && gpio_hit;

        if (gpio_hit) begin
            m_rsp = gpio_rsp;
        end else begin
            // unmapped, finish on the first access cycle
            m_rsp.prdata = '0;
            m_rsp.pready = m_req.psel && m_req.penable;
        end
    end

    // no slave may complete outside the access phase
    always_comb begin
        a_ready_in_access: assert final (!m_rsp.pready || (m_req.psel && m_req.penable));
    end

endmodule

// File: hdl/vm16_gpio.sv
/* APB slave holding the 16-bit GPIO output register
   gpio_write pulses for one cycle after each write, with gpio already updated */
`timescale 1ns/1ps

module vm16_gpio (
    input  logic                        clk,
    input  logic                        reset,
    input  vm16_pkg::apb_req_t          s_req,
    output vm16_pkg::apb_rsp_t          s_rsp,
    output logic [vm16_pkg::word_w-1:0] gpio,
    output logic                        gpio_write
);

    logic access;

    assign access = s_req.psel && s_req.penable;

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio       <= '0;
            gpio_write <= 1'b0;
        end else begin
            gpio_write <= access && s_req.pwrite;
            if (access && s_req.pwrite) begin
                gpio <= s_req.pwdata;
            end
        end
    end

    // zero wait states
    assign s_rsp.pready = access;
    assign s_rsp.prdata = (access && !s_req.pwrite) ? gpio : '0;

endmodule

// File: hdl/vm16_core.sv
/* multicycle vm16 core, IF R1 R2 (ME) WB per instruction
   instruction RAM is loaded through the program port while run is low */
`timescale 1ns/1ps

module vm16_core (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          prog_we,
    input  logic [vm16_pkg::instr_aw-1:0] prog_addr,
    input  logic [vm16_pkg::word_w-1:0]   prog_data,
    output vm16_pkg::apb_req_t            apb_m,
    input  vm16_pkg::apb_rsp_t            apb_s
);

    vm16_pkg::core_state_t           state;
    logic [vm16_pkg::instr_aw-1:0]   pc;
    logic [vm16_pkg::word_w-1:0]     iram_rdata;
    logic [vm16_pkg::word_w-1:0]     instr;
    vm16_pkg::dec_t                  dec;
    logic [vm16_pkg::reg_sel_w-1:0]  rs;
    logic [vm16_pkg::word_w-1:0]     rs_val;
    logic [vm16_pkg::word_w-1:0]     op_a;
    logic [vm16_pkg::word_w-1:0]     op_b;
    logic [vm16_pkg::word_w-1:0]     alu_c;
    logic                            req;
    vm16_pkg::mem_req_t              mreq;
    logic                            done;
    logic [vm16_pkg::word_w-1:0]     mem_rdata;
    logic [vm16_pkg::word_w-1:0]     mem_data;

    // program port owns the RAM while idle
    vm16_bram #(
        .depth (vm16_pkg::instr_depth)
    ) u_iram (
        .clk   (clk),
        .addr  (run ? pc : prog_addr),
        .wdata (prog_data),
        .we    (prog_we && !run),
        .rdata (iram_rdata)
    );

    vm16_decoder u_dec (
        .instr (instr),
        .dec   (dec)
    );

    // in R1 the fetched word is still on the RAM output, rd is bits 10:8
    assign rs = (state == vm16_pkg::R1) ? iram_rdata[10:8] : dec.ra;

    vm16_regfile u_regs (
        .clk   (clk),
        .reset (reset),
        .rs    (rs),
        .rd    (rs_val),
        .we    (dec.has_we && state == vm16_pkg::WB),
        .ws    (dec.rd),
        .wd    (dec.has_mem ? mem_data : alu_c)
    );

    vm16_alu u_alu (
        .op (dec.alu_op),
        .a  (op_a),
        .b  (op_b),
        .c  (alu_c)
    );

    assign mreq.addr  = alu_c + {{(vm16_pkg::word_w-5){1'b0}}, dec.simm5};
    assign mreq.wdata = op_a;
    assign mreq.we    = dec.has_mem_we;

    vm16_mmu u_mmu (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .mreq  (mreq),
        .done  (done),
        .rdata (mem_rdata),
        .apb_m (apb_m),
        .apb_s (apb_s)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= vm16_pkg::IF;
            pc    <= '0;
            req   <= 1'b0;
        end else begin
            req <= 1'b0;
            case (state)
                vm16_pkg::IF: begin
                    if (run) begin
                        state <= vm16_pkg::R1;
                        // last word repeats forever
                        if (pc != vm16_pkg::instr_aw'(vm16_pkg::instr_depth - 1)) begin
                            pc <= pc + 1'b1;
                        end
                    end
                end
                vm16_pkg::R1: state <= vm16_pkg::R2;
                vm16_pkg::R2: begin
                    if (dec.has_mem) begin
                        state <= vm16_pkg::ME;
                        req   <= 1'b1;
                    end else begin
                        state <= vm16_pkg::WB;
                    end
                end
                vm16_pkg::ME: begin
                    if (done) begin
                        state <= vm16_pkg::WB;
                    end
                end
                default: state <= vm16_pkg::IF;
            endcase
        end
    end

    // operands and load data
    always_ff @(posedge clk) begin
        if (state == vm16_pkg::R1) begin
            instr <= iram_rdata;
            op_a  <= rs_val;
        end
        if (state == vm16_pkg::R2) begin
            op_b <= dec.has_imm8 ? {{(vm16_pkg::word_w-8){1'b0}}, dec.imm8} : rs_val;
        end
        if (state == vm16_pkg::ME && done) begin
            mem_data <= mem_rdata;
        end
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (reset)
        state inside {vm16_pkg::IF, vm16_pkg::R1, vm16_pkg::R2, vm16_pkg::ME, vm16_pkg::WB}
    );

endmodule

// File: hdl/vm16_soc.sv
/* top level, one vm16 core on an APB fabric with the GPIO peripheral
   load the program with run low, then raise run */
`timescale 1ns/1ps

module vm16_soc (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  logic                          prog_we,
    input  logic [vm16_pkg::instr_aw-1:0] prog_addr,
    input  logic [vm16_pkg::word_w-1:0]   prog_data,
    output logic [vm16_pkg::word_w-1:0]   gpio,
    output logic                          gpio_write
);

    vm16_pkg::apb_req_t m_req;
    vm16_pkg::apb_rsp_t m_rsp;
    vm16_pkg::apb_req_t gpio_req;
    vm16_pkg::apb_rsp_t gpio_rsp;

    vm16_core u_core (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .apb_m     (m_req),
        .apb_s     (m_rsp)
    );

    vm16_apb_fabric u_fabric (
        .m_req    (m_req),
        .m_rsp    (m_rsp),
        .gpio_req (gpio_req),
        .gpio_rsp (gpio_rsp)
    );

    vm16_gpio u_gpio (
        .clk        (clk),
        .reset      (reset),
        .s_req      (gpio_req),
        .s_rsp      (gpio_rsp),
        .gpio       (gpio),
        .gpio_write (gpio_write)
    );

endmodule

// File: test/vm16_clk_gen.sv
/* testbench clock and power-on reset, 10 ns period with reset high for two cycles */
`timescale 1ns/1ps

module vm16_clk_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // released 1 ns after the edge like every other driven input
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// File: test/vm16_tb.sv
/* vm16 SoC testbench, random programs run on the core and on an ISA model
   every GPIO store of the DUT is compared with the model's next store */
`timescale 1ns/1ps

module vm16_tb;

    localparam int prog_len     = 40;
    localparam int pulse_limit  = 400;
    localparam int quiet_cycles = 300;

    logic                          clk;
    logic                          por_reset;
    logic                          sw_reset;
    logic                          reset;
    logic                          run;
    logic                          prog_we;
    logic [vm16_pkg::instr_aw-1:0] prog_addr;
    logic [vm16_pkg::word_w-1:0]   prog_data;
    logic [vm16_pkg::word_w-1:0]   gpio;
    logic                          gpio_write;

    // program image and reference state
    logic [15:0] prog [vm16_pkg::instr_depth];
    int          prog_cnt;
    logic [15:0] model_regs [vm16_pkg::num_regs];
    logic [15:0] model_tim0 [vm16_pkg::tim0_depth];
    logic [15:0] model_gpio;
    logic [15:0] expected [$];
    int          stored_addr [$];
    logic [31:0] rng_state;

    assign reset = por_reset | sw_reset;

    vm16_clk_gen u_clk (
        .clk   (clk),
        .reset (por_reset)
    );

    vm16_soc u_dut (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .gpio       (gpio),
        .gpio_write (gpio_write)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function int unsigned rand_below(input int unsigned n);
        rng_state = xorshift(rng_state);
        return rng_state % n;
    endfunction

    function automatic logic [15:0] enc_reg(input logic [4:0] op, input int rd, input int ra,
                                            input logic [4:0] low);
        return {op, 3'(rd), 3'(ra), low};
    endfunction

    function automatic logic [15:0] enc_imm(input int rd, input logic [7:0] imm);
        return {5'(vm16_pkg::MOVI), 3'(rd), imm};
    endfunction

    // ISA result for register ops, a is rd and b is ra or the immediate
    function automatic logic [15:0] ref_result(input logic [4:0] op, input logic [4:0] sub,
                                               input logic [15:0] a, input logic [15:0] b);
        logic [15:0] r;
        r = 16'h0;
        if (op == vm16_pkg::MOV || op == vm16_pkg::MOVI) begin
            r = b;
        end else if (op == vm16_pkg::BIT) begin
            case (sub)
                vm16_pkg::BIT_OR:    r = a | b;
                vm16_pkg::BIT_XOR:   r = a ^ b;
                vm16_pkg::BIT_AND:   r = a & b;
                vm16_pkg::BIT_NOT:   r = ~b;
                vm16_pkg::BIT_LSHFT: r = (b > 16'd15) ? 16'h0 : a << b[3:0];
                vm16_pkg::BIT_RSHFT: r = (b > 16'd15) ? 16'h0 : a >> b[3:0];
                default:             r = 16'h0;
            endcase
        end else if (op == vm16_pkg::ARITH_U || op == vm16_pkg::ARITH_S) begin
            // two's complement add and subtract wrap the same for both kinds
            if (sub == vm16_pkg::ARITH_UADD) begin
                r = a + b;
            end else if (sub == vm16_pkg::ARITH_USUB) begin
                r = a - b;
            end
        end
        return r;
    endfunction

    task automatic model_step(input logic [15:0] instr);
        logic [4:0]  op;
        logic [2:0]  rd;
        logic [2:0]  ra;
        logic [15:0] addr;
        op   = instr[15:11];
        rd   = instr[10:8];
        ra   = instr[7:5];
        addr = model_regs[ra] + {11'h0, instr[4:0]};
        if (op == vm16_pkg::LW) begin
            if (addr <= vm16_pkg::addr_tim0_end) begin
                model_regs[rd] = model_tim0[addr[5:0]];
            end else if (addr == vm16_pkg::addr_gpio) begin
                model_regs[rd] = model_gpio;
            end else begin
                model_regs[rd] = 16'h0;
            end
        end else if (op == vm16_pkg::SW) begin
            if (addr <= vm16_pkg::addr_tim0_end) begin
                model_tim0[addr[5:0]] = model_regs[rd];
            end else if (addr == vm16_pkg::addr_gpio) begin
                model_gpio = model_regs[rd];
                expected.push_back(model_gpio);
            end
        end else if (op == vm16_pkg::MOVI) begin
            model_regs[rd] = {8'h0, instr[7:0]};
        end else if (op == vm16_pkg::MOV || op == vm16_pkg::BIT
                     || op == vm16_pkg::ARITH_U || op == vm16_pkg::ARITH_S) begin
            // NOP and unknown opcodes leave the registers alone
            model_regs[rd] = ref_result(op, instr[4:0], model_regs[rd], model_regs[ra]);
        end
    endtask

    task automatic emit(input logic [15:0] instr);
        prog[prog_cnt] = instr;
        prog_cnt++;
        model_step(instr);
    endtask

    // registers back to their index, image filled with NOP
    task automatic begin_program();
        int i;
        for (i = 0; i < vm16_pkg::num_regs; i++) begin
            model_regs[i] = 16'(i);
        end
        for (i = 0; i < vm16_pkg::instr_depth; i++) begin
            prog[i] = 16'h0;
        end
        model_gpio = 16'h0;
        prog_cnt   = 0;
        expected.delete();
        stored_addr.delete();
    endtask

    // r7 is parked in TIM0 before it becomes the GPIO base
    task automatic build_reset_program();
        int r;
        emit(enc_reg(vm16_pkg::SW, 7, 0, 5'd0));
        emit(enc_imm(7, 8'hC0));
        for (r = 0; r < 7; r++) begin
            emit(enc_reg(vm16_pkg::SW, r, 7, 5'd0));
        end
        emit(enc_reg(vm16_pkg::LW, 6, 0, 5'd0));
        emit(enc_reg(vm16_pkg::SW, 6, 7, 5'd0));
    endtask

    task automatic build_alu_program();
        int rd;
        int ra;
        emit(enc_imm(7, 8'hC0));
        while (prog_cnt + 2 <= prog_len) begin
            rd = rand_below(7);
            ra = rand_below(8);
            case (rand_below(5))
                0: emit(enc_imm(rd, 8'(rand_below(256))));
                1: emit(enc_reg(vm16_pkg::MOV, rd, ra, 5'(rand_below(32))));
                2: emit(enc_reg(vm16_pkg::BIT, rd, ra, 5'(rand_below(6))));
                3: emit(enc_reg(vm16_pkg::ARITH_U, rd, ra,
                        rand_below(2) ? vm16_pkg::ARITH_UADD : vm16_pkg::ARITH_USUB));
                default: emit(enc_reg(vm16_pkg::ARITH_S, rd, ra,
                        rand_below(2) ? vm16_pkg::ARITH_SADD : vm16_pkg::ARITH_SSUB));
            endcase
            emit(enc_reg(vm16_pkg::SW, rd, 7, 5'd0));
        end
    endtask

    task automatic build_mem_program();
        int a;
        int off;
        int rd;
        emit(enc_imm(7, 8'hC0));
        // TIM0 stores through r6 as base
        repeat (5) begin
            a   = rand_below(64);
            off = rand_below(((a < 31) ? a : 31) + 1);
            rd  = rand_below(6);
            emit(enc_imm(rd, 8'(rand_below(256))));
            emit(enc_imm(6, 8'(a - off)));
            emit(enc_reg(vm16_pkg::SW, rd, 6, 5'(off)));
            stored_addr.push_back(a);
        end
        repeat (4) begin
            a   = stored_addr[rand_below(stored_addr.size())];
            off = rand_below(((a < 31) ? a : 31) + 1);
            emit(enc_imm(6, 8'(a - off)));
            emit(enc_reg(vm16_pkg::LW, 0, 6, 5'(off)));
            emit(enc_reg(vm16_pkg::SW, 0, 7, 5'd0));
        end
        // GPIO read back over APB
        emit(enc_imm(2, 8'(rand_below(256))));
        emit(enc_reg(vm16_pkg::SW, 2, 7, 5'd0));
        emit(enc_reg(vm16_pkg::LW, 1, 7, 5'd0));
        emit(enc_reg(vm16_pkg::SW, 1, 7, 5'd0));
        // unmapped window 0x90 to 0xAF reads zero
        emit(enc_imm(3, 8'h5A));
        emit(enc_imm(6, 8'h90));
        emit(enc_reg(vm16_pkg::LW, 3, 6, 5'(rand_below(32))));
        emit(enc_reg(vm16_pkg::SW, 3, 7, 5'd0));
    endtask

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic run_program();
        int          i;
        int          cycles;
        logic [15:0] exp_val;
        @(posedge clk);
        #1;
        run      = 1'b0;
        sw_reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 sw_reset = 1'b0;
        for (i = 0; i < vm16_pkg::instr_depth; i++) begin
            prog_we   = 1'b1;
            prog_addr = vm16_pkg::instr_aw'(i);
            prog_data = prog[i];
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
        @(negedge clk);
        assert (gpio == 16'h0) else begin
            $display("ERROR %0t: gpio after reset expected 0000, seen %04h", $time, gpio);
            stop_with_failure();
        end
        @(posedge clk);
        #1 run = 1'b1;
        while (expected.size() > 0) begin
            exp_val = expected.pop_front();
            cycles  = 0;
            do begin
                @(negedge clk);
                cycles++;
            end while (!gpio_write && cycles < pulse_limit);
            assert (gpio_write) else begin
                $display("Timed out waiting for the next GPIO write.");
                stop_with_failure();
            end
            assert (gpio == exp_val) else begin
                $display("ERROR %0t: gpio expected %04h, seen %04h", $time, exp_val, gpio);
                stop_with_failure();
            end
        end
        // tail of NOPs must stay quiet
        repeat (quiet_cycles) begin
            @(negedge clk);
            assert (!gpio_write) else begin
                $display("A GPIO write happened after the program's last store.");
                stop_with_failure();
            end
        end
    endtask

    initial begin
        int i;
        int round;
        sw_reset  = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        rng_state = 32'd98813;
        for (i = 0; i < vm16_pkg::tim0_depth; i++) begin
            model_tim0[i] = 16'h0;
        end
        begin_program();
        build_reset_program();
        run_program();
        for (round = 0; round < 3; round++) begin
            begin_program();
            build_alu_program();
            run_program();
            begin_program();
            build_mem_program();
            run_program();
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: flist.f
hdl/vm16_pkg.sv
hdl/vm16_bram.sv
hdl/vm16_decoder.sv
hdl/vm16_alu.sv
hdl/vm16_regfile.sv
hdl/vm16_mmu.sv
hdl/vm16_apb_fabric.sv
hdl/vm16_gpio.sv
hdl/vm16_core.sv
hdl/vm16_soc.sv
test/vm16_clk_gen.sv
test/vm16_tb.sv
